// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= rv_core_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_instr,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_ex_result,
    input  logic [XLEN-1:0] i_mem_result,
    input  logic [XLEN-1:0] i_wb_data,
    input  logic            i_load_stall,
    input  logic            i_freeze,
    hazard_if.decode        hz,
    output reg_idx_t        o_rs1_addr,
    output reg_idx_t        o_rs2_addr,
    output alu_op_e         o_alu_op,
    output logic [XLEN-1:0] o_op_a,
    output logic [XLEN-1:0] o_op_b,
    output logic [XLEN-1:0] o_store_data,
    output reg_idx_t        o_rd,
    output logic            o_wr_en,
    output logic            o_is_load,
    output logic            o_is_store,
    output logic            o_ecall
);

    opcode_e         src_op;
    opcode_e         ctl_op;
    logic [XLEN-1:0] dec_instr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    alu_op_e         alu_op;
    logic            wr_en;
    logic            is_load;
    logic            is_store;
    logic            ecall;

    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        case (f3)
            3'b000:  funct_to_alu = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  funct_to_alu = ALU_SLL;
            3'b010:  funct_to_alu = ALU_SLT;
            3'b011:  funct_to_alu = ALU_SLTU;
            3'b100:  funct_to_alu = ALU_XOR;
            3'b101:  funct_to_alu = alt ? ALU_SRA : ALU_SRL;
            3'b110:  funct_to_alu = ALU_OR;
            default: funct_to_alu = ALU_AND;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] fwd_pick(input fwd_sel_e sel,
                                                 input logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_EX:  fwd_pick = i_ex_result;
            FWD_MEM: fwd_pick = i_mem_result;
            FWD_WB:  fwd_pick = i_wb_data;
            default: fwd_pick = rf_val;
        endcase
    endfunction

    // Source fields always come from the real instruction
    assign src_op     = opcode_e'(i_instr[6:0]);
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];
    assign hz.rs1     = i_instr[19:15];
    assign hz.rs2     = i_instr[24:20];
    assign hz.use_rs1 = (src_op == OP_REG) || (src_op == OP_IMM) ||
                        (src_op == OP_LOAD) || (src_op == OP_STORE);
    assign hz.use_rs2 = (src_op == OP_REG) || (src_op == OP_STORE);

    assign rs1_val = fwd_pick(hz.fwd_rs1, i_rs1_data);
    assign rs2_val = fwd_pick(hz.fwd_rs2, i_rs2_data);

    // A load-use stall sends a decoded NOP into execute
    assign dec_instr = i_load_stall ? NOP_INSTR : i_instr;
    assign ctl_op    = opcode_e'(dec_instr[6:0]);

    always_comb
    begin
        alu_op   = ALU_ADD;
        imm      = {{20{dec_instr[31]}}, dec_instr[31:20]};      // I-type
        wr_en    = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        ecall    = 1'b0;
        case (ctl_op)
            OP_REG:
            begin
                alu_op = funct_to_alu(dec_instr[14:12], dec_instr[30], 1'b1);
                wr_en  = 1'b1;
            end
            OP_IMM:
            begin
                alu_op = funct_to_alu(dec_instr[14:12], dec_instr[30], 1'b0);
                wr_en  = 1'b1;
            end
            OP_LUI:
            begin
                alu_op = ALU_PASS_B;
                imm    = {dec_instr[31:12], 12'b0};
                wr_en  = 1'b1;
            end
            OP_LOAD:
            begin
                is_load = 1'b1;
                wr_en   = 1'b1;
            end
            OP_STORE:
            begin
                imm      = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
                is_store = 1'b1;
            end
            OP_SYSTEM: ecall = (dec_instr[31:7] == '0);
            default: ;      // Unknown opcode behaves as a NOP
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wr_en    <= 1'b0;
            o_is_load  <= 1'b0;
            o_is_store <= 1'b0;
            o_ecall    <= 1'b0;
        end
        else if (!i_freeze)
        begin
            o_wr_en    <= wr_en;
            o_is_load  <= is_load;
            o_is_store <= is_store;
            o_ecall    <= ecall;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_freeze)
        begin
            o_alu_op     <= alu_op;
            o_op_a       <= rs1_val;
            o_op_b       <= (ctl_op == OP_REG) ? rs2_val : imm;
            o_store_data <= rs2_val;
            o_rd         <= dec_instr[11:7];
        end
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_freeze,
    input  alu_op_e         i_alu_op,
    input  logic [XLEN-1:0] i_op_a,
    input  logic [XLEN-1:0] i_op_b,
    input  logic [XLEN-1:0] i_store_data,
    input  reg_idx_t        i_rd,
    input  logic            i_wr_en,
    input  logic            i_is_load,
    input  logic            i_is_store,
    input  logic            i_ecall,
    output logic [XLEN-1:0] o_ex_result,
    output reg_idx_t        o_ex_rd,
    output logic            o_ex_wr_en,
    output logic            o_ex_is_load,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output reg_idx_t        o_mem_rd,
    output logic            o_mem_wr_en,
    output logic            o_mem_load,
    output logic            o_mem_store,
    output logic            o_mem_ecall
);

    logic [4:0] shamt;

    assign shamt = i_op_b[4:0];

    always_comb
    begin
        case (i_alu_op)
            ALU_SUB:    o_ex_result = i_op_a - i_op_b;
            ALU_SLL:    o_ex_result = i_op_a << shamt;
            ALU_SLT:    o_ex_result = {31'b0, $signed(i_op_a) < $signed(i_op_b)};
            ALU_SLTU:   o_ex_result = {31'b0, i_op_a < i_op_b};
            ALU_XOR:    o_ex_result = i_op_a ^ i_op_b;
            ALU_SRL:    o_ex_result = i_op_a >> shamt;
            ALU_SRA:    o_ex_result = $signed(i_op_a) >>> shamt;
            ALU_OR:     o_ex_result = i_op_a | i_op_b;
            ALU_AND:    o_ex_result = i_op_a & i_op_b;
            ALU_PASS_B: o_ex_result = i_op_b;
            default:    o_ex_result = i_op_a + i_op_b;      // ADD, load and store address
        endcase
    end

    // Execute forwarding and load-use terms
    assign o_ex_rd      = i_rd;
    assign o_ex_wr_en   = i_wr_en;
    assign o_ex_is_load = i_is_load;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_mem_wr_en <= 1'b0;
            o_mem_load  <= 1'b0;
            o_mem_store <= 1'b0;
            o_mem_ecall <= 1'b0;
        end
        else if (!i_freeze)
        begin
            o_mem_wr_en <= i_wr_en;
            o_mem_load  <= i_is_load;
            o_mem_store <= i_is_store;
            o_mem_ecall <= i_ecall;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_freeze)
        begin
            o_mem_addr  <= o_ex_result;
            o_mem_wdata <= i_store_data;
            o_mem_rd    <= i_rd;
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDRESS = '0
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_instr,
    input  logic            i_load_stall,
    input  logic            i_freeze,
    output logic [XLEN-1:0] o_pc,
    output logic            o_instr_rd,
    output logic [XLEN-1:0] o_id_instr
);

    logic hold;

    assign hold = i_load_stall || i_freeze;

    assign o_instr_rd = !i_rst;     // Fetching whenever out of reset

    // PC and fetch/decode register move as one
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_pc       <= BOOT_ADDRESS;
            o_id_instr <= NOP_INSTR;
        end
        else
        begin
            if (!hold)
            begin
                o_pc       <= o_pc + 32'd4;
                o_id_instr <= i_instr;      // Memory answers in the same cycle
            end
        end
    end

endmodule

// ==== design/hazard_if.sv ====
`timescale 1ns/10ps

interface hazard_if import rv_pkg::*; ();

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_rs1;      // Instruction in decode reads rs1
    logic     use_rs2;
    fwd_sel_e fwd_rs1;
    fwd_sel_e fwd_rs2;

    modport decode (
        output rs1, rs2, use_rs1, use_rs2,
        input  fwd_rs1, fwd_rs2
    );

    modport hazard (
        input  rs1, rs2, use_rs1, use_rs2,
        output fwd_rs1, fwd_rs2
    );

endinterface

// ==== design/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit import rv_pkg::*; (
    hazard_if.hazard hz,
    input  reg_idx_t i_ex_rd,
    input  logic     i_ex_wr_en,
    input  logic     i_ex_is_load,
    input  reg_idx_t i_mem_rd,
    input  logic     i_mem_wr_en,
    input  logic     i_mem_busy,
    input  reg_idx_t i_wb_rd,
    input  logic     i_wb_wr_en,
    output logic     o_load_stall,
    output logic     o_freeze
);

    logic ex_load_hit;

    // Youngest writer wins
    function automatic fwd_sel_e pick_source(input reg_idx_t rs, input logic used);
        if (!used || (rs == '0))
            pick_source = FWD_RF;
        else if (i_ex_wr_en && !i_ex_is_load && (i_ex_rd == rs))
            pick_source = FWD_EX;
        else if (i_mem_wr_en && !i_mem_busy && (i_mem_rd == rs))
            pick_source = FWD_MEM;
        else if (i_wb_wr_en && (i_wb_rd == rs))
            pick_source = FWD_WB;
        else
            pick_source = FWD_RF;
    endfunction

    assign hz.fwd_rs1 = pick_source(hz.rs1, hz.use_rs1);
    assign hz.fwd_rs2 = pick_source(hz.rs2, hz.use_rs2);

    // Load data only exists one stage later
    assign ex_load_hit = i_ex_is_load && i_ex_wr_en && (i_ex_rd != '0);

    assign o_load_stall = ex_load_hit &&
                          ((hz.use_rs1 && (hz.rs1 == i_ex_rd)) ||
                           (hz.use_rs2 && (hz.rs2 == i_ex_rd)));

    assign o_freeze = i_mem_busy;

endmodule

// ==== design/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_addr,
    input  logic [XLEN-1:0] i_wdata,
    input  reg_idx_t        i_rd,
    input  logic            i_wr_en,
    input  logic            i_load,
    input  logic            i_store,
    input  logic            i_ecall,
    input  logic [XLEN-1:0] i_data_mem_out,
    input  logic            i_dcache_done,
    output logic [XLEN-1:0] o_data_mem_addr,
    output logic            o_data_mem_en,
    output logic            o_data_mem_rd_wr,
    output logic [XLEN-1:0] o_data_mem_in,
    output logic            o_mem_busy,
    output logic [XLEN-1:0] o_mem_result,
    output reg_idx_t        o_mem_rd,
    output logic            o_mem_wr_en,
    output reg_idx_t        o_wb_rd,
    output logic            o_wb_wr_en,
    output logic [XLEN-1:0] o_wb_data,
    output logic            o_ecall
);

    logic access;

    assign access = i_load || i_store;

    // Port levels come straight from the held execute/memory register
    assign o_data_mem_en    = access;
    assign o_data_mem_rd_wr = i_store;     // 1 is a write
    assign o_data_mem_addr  = i_addr;
    assign o_data_mem_in    = i_wdata;

    assign o_mem_busy   = access && !i_dcache_done;
    assign o_mem_result = (i_load && i_dcache_done) ? i_data_mem_out : i_addr;
    assign o_mem_rd     = i_rd;
    assign o_mem_wr_en  = i_wr_en;

    // Bubble into write-back on every busy cycle
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wb_wr_en <= 1'b0;
            o_ecall    <= 1'b0;
        end
        else
        begin
            o_wb_wr_en <= i_wr_en && !o_mem_busy;
            o_ecall    <= i_ecall && !o_mem_busy;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd   <= i_rd;
        o_wb_data <= o_mem_result;
    end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/10ps

module register_file import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  reg_idx_t        i_rs1_addr,
    input  reg_idx_t        i_rs2_addr,
    input  reg_idx_t        i_rd_addr,
    input  logic            i_wr_en,
    input  logic [XLEN-1:0] i_rd_data,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data
);

    logic [XLEN-1:0] regs [1:31];       // No storage behind x0

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wr_en && (i_rd_addr != '0))
            regs[i_rd_addr] <= i_rd_data;
    end

    // Asynchronous reads
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDRESS = '0
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_instr,
    output logic            o_instr_mem_rd,
    output logic [XLEN-1:0] o_instr_mem_addr,
    input  logic [XLEN-1:0] i_data_mem_out,
    input  logic            i_dcache_done,
    output logic [XLEN-1:0] o_data_mem_addr,
    output logic            o_data_mem_en,
    output logic            o_data_mem_rd_wr,
    output logic [XLEN-1:0] o_data_mem_in,
    output logic            o_ecall
);

    logic [XLEN-1:0] id_instr;
    reg_idx_t        rs1_addr;
    reg_idx_t        rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // Decode/execute register
    alu_op_e         de_alu_op;
    logic [XLEN-1:0] de_op_a;
    logic [XLEN-1:0] de_op_b;
    logic [XLEN-1:0] de_store_data;
    reg_idx_t        de_rd;
    logic            de_wr_en;
    logic            de_is_load;
    logic            de_is_store;
    logic            de_ecall;

    logic [XLEN-1:0] ex_result;
    reg_idx_t        ex_rd;
    logic            ex_wr_en;
    logic            ex_is_load;

    // Execute/memory register
    logic [XLEN-1:0] em_addr;
    logic [XLEN-1:0] em_wdata;
    reg_idx_t        em_rd;
    logic            em_wr_en;
    logic            em_load;
    logic            em_store;
    logic            em_ecall;

    logic            mem_busy;
    logic [XLEN-1:0] mem_result;
    reg_idx_t        mem_rd;
    logic            mem_wr_en;
    reg_idx_t        wb_rd;
    logic            wb_wr_en;
    logic [XLEN-1:0] wb_data;

    logic            load_stall;
    logic            freeze;

    hazard_if hz_if ();

    fetch_unit #(
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_instr      (i_instr),
        .i_load_stall (load_stall),
        .i_freeze     (freeze),
        .o_pc         (o_instr_mem_addr),
        .o_instr_rd   (o_instr_mem_rd),
        .o_id_instr   (id_instr)
    );

    decode_stage u_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_instr      (id_instr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_ex_result  (ex_result),
        .i_mem_result (mem_result),
        .i_wb_data    (wb_data),
        .i_load_stall (load_stall),
        .i_freeze     (freeze),
        .hz           (hz_if.decode),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_alu_op     (de_alu_op),
        .o_op_a       (de_op_a),
        .o_op_b       (de_op_b),
        .o_store_data (de_store_data),
        .o_rd         (de_rd),
        .o_wr_en      (de_wr_en),
        .o_is_load    (de_is_load),
        .o_is_store   (de_is_store),
        .o_ecall      (de_ecall)
    );

    register_file u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_rd_addr  (wb_rd),
        .i_wr_en    (wb_wr_en),
        .i_rd_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_stage u_execute (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_freeze     (freeze),
        .i_alu_op     (de_alu_op),
        .i_op_a       (de_op_a),
        .i_op_b       (de_op_b),
        .i_store_data (de_store_data),
        .i_rd         (de_rd),
        .i_wr_en      (de_wr_en),
        .i_is_load    (de_is_load),
        .i_is_store   (de_is_store),
        .i_ecall      (de_ecall),
        .o_ex_result  (ex_result),
        .o_ex_rd      (ex_rd),
        .o_ex_wr_en   (ex_wr_en),
        .o_ex_is_load (ex_is_load),
        .o_mem_addr   (em_addr),
        .o_mem_wdata  (em_wdata),
        .o_mem_rd     (em_rd),
        .o_mem_wr_en  (em_wr_en),
        .o_mem_load   (em_load),
        .o_mem_store  (em_store),
        .o_mem_ecall  (em_ecall)
    );

    memory_stage u_memory (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_addr           (em_addr),
        .i_wdata          (em_wdata),
        .i_rd             (em_rd),
        .i_wr_en          (em_wr_en),
        .i_load           (em_load),
        .i_store          (em_store),
        .i_ecall          (em_ecall),
        .i_data_mem_out   (i_data_mem_out),
        .i_dcache_done    (i_dcache_done),
        .o_data_mem_addr  (o_data_mem_addr),
        .o_data_mem_en    (o_data_mem_en),
        .o_data_mem_rd_wr (o_data_mem_rd_wr),
        .o_data_mem_in    (o_data_mem_in),
        .o_mem_busy       (mem_busy),
        .o_mem_result     (mem_result),
        .o_mem_rd         (mem_rd),
        .o_mem_wr_en      (mem_wr_en),
        .o_wb_rd          (wb_rd),
        .o_wb_wr_en       (wb_wr_en),
        .o_wb_data        (wb_data),
        .o_ecall          (o_ecall)
    );

    hazard_unit u_hazard (
        .hz           (hz_if.hazard),
        .i_ex_rd      (ex_rd),
        .i_ex_wr_en   (ex_wr_en),
        .i_ex_is_load (ex_is_load),
        .i_mem_rd     (mem_rd),
        .i_mem_wr_en  (mem_wr_en),
        .i_mem_busy   (mem_busy),
        .i_wb_rd      (wb_rd),
        .i_wb_wr_en   (wb_wr_en),
        .o_load_stall (load_stall),
        .o_freeze     (freeze)
    );

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_idx_t;

    // Major opcode field, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B        // LUI result is the U immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== verification/rv_core_assert.sv ====
`timescale 1ns/10ps

module rv_core_assert import rv_pkg::*; (
    input logic            i_clk,
    input logic            i_rst,
    input logic            i_dcache_done,
    input logic            o_instr_mem_rd,
    input logic [XLEN-1:0] o_instr_mem_addr,
    input logic [XLEN-1:0] o_data_mem_addr,
    input logic            o_data_mem_en,
    input logic            o_data_mem_rd_wr,
    input logic [XLEN-1:0] o_data_mem_in,
    input logic            o_ecall
);

    int fail_count = 0;     // Failed assertions so far

    // Pending access keeps its levels until done
    property data_port_stable;
        @(posedge i_clk) disable iff (i_rst)
        (o_data_mem_en && !i_dcache_done) |=>
            (o_data_mem_en && $stable(o_data_mem_addr) && $stable(o_data_mem_rd_wr) &&
             $stable(o_data_mem_in));
    endproperty

    property ecall_single_cycle;
        @(posedge i_clk) disable iff (i_rst)
        o_ecall |=> !o_ecall;
    endproperty

    property outputs_known;
        @(posedge i_clk) disable iff (i_rst)
        !$isunknown({o_instr_mem_rd, o_instr_mem_addr, o_data_mem_addr, o_data_mem_en,
                     o_data_mem_rd_wr, o_data_mem_in, o_ecall});
    endproperty

    a_data_port_stable: assert property (data_port_stable)
        else
        begin
            $error("Data port levels changed before done");
            fail_count++;
        end
    a_ecall_single: assert property (ecall_single_cycle)
        else
        begin
            $error("o_ecall stayed high for two cycles");
            fail_count++;
        end
    a_outputs_known: assert property (outputs_known)
        else
        begin
            $error("Unknown value on a core output");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_dcache_done    (i_dcache_done),
    .o_instr_mem_rd   (o_instr_mem_rd),
    .o_instr_mem_addr (o_instr_mem_addr),
    .o_data_mem_addr  (o_data_mem_addr),
    .o_data_mem_en    (o_data_mem_en),
    .o_data_mem_rd_wr (o_data_mem_rd_wr),
    .o_data_mem_in    (o_data_mem_in),
    .o_ecall          (o_ecall)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

    localparam int          CLK_PERIOD = 40;
    localparam int          TIMEOUT    = 2000;
    localparam int          N_RANDOM   = 60;
    localparam int          IMEM_WORDS = 128;
    localparam int          DMEM_WORDS = 128;
    localparam int          EPI_BASE   = 256;      // Above the 64-word random window
    localparam logic [31:0] SEED       = 32'h641b_4f6a;

    logic            i_clk;
    logic            i_rst;
    logic [XLEN-1:0] i_instr;
    logic            o_instr_mem_rd;
    logic [XLEN-1:0] o_instr_mem_addr;
    logic [XLEN-1:0] i_data_mem_out;
    logic            i_dcache_done;
    logic [XLEN-1:0] o_data_mem_addr;
    logic            o_data_mem_en;
    logic            o_data_mem_rd_wr;
    logic [XLEN-1:0] o_data_mem_in;
    logic            o_ecall;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] model_regs [8];
    logic [XLEN-1:0] model_mem [DMEM_WORDS];
    logic [XLEN-1:0] exp_st_addr [$];
    logic [XLEN-1:0] exp_st_data [$];
    logic [XLEN-1:0] exp_ld_addr [$];
    int              errors;
    int              checks;
    int              ecall_count;
    int              wait_cnt;
    logic            pending;          // Data access already has a drawn delay

    rv_core #(
        .BOOT_ADDRESS ('0)
    ) dut_i (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_instr          (i_instr),
        .o_instr_mem_rd   (o_instr_mem_rd),
        .o_instr_mem_addr (o_instr_mem_addr),
        .i_data_mem_out   (i_data_mem_out),
        .i_dcache_done    (i_dcache_done),
        .o_data_mem_addr  (o_data_mem_addr),
        .o_data_mem_en    (o_data_mem_en),
        .o_data_mem_rd_wr (o_data_mem_rd_wr),
        .o_data_mem_in    (o_data_mem_in),
        .o_ecall          (o_ecall)
    );

    assign i_instr = imem[o_instr_mem_addr[8:2]];      // Combinational instruction port

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return (32'h9e37_79b9 * 32'(idx + 1)) ^ 32'(idx << 20);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I integer semantics with alt selecting SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Builds the program and runs it on the model at the same time
    task automatic gen_program();
        int          kind;
        int          rd;
        int          rs1;
        int          rs2;
        int          k;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [31:0] val;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = NOP_INSTR;
        for (int i = 0; i < DMEM_WORDS; i++)
        begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 8; i++)
            model_regs[i] = '0;
        for (int n = 0; n < N_RANDOM; n++)
        begin
            kind = $urandom_range(7, 0);
            rd   = $urandom_range(7, 0);
            rs1  = $urandom_range(7, 0);
            rs2  = $urandom_range(7, 0);
            k    = $urandom_range(63, 0);
            f3   = 3'($urandom_range(7, 0));
            alt  = 1'b0;
            imm  = 12'($urandom);
            uimm = 20'($urandom);
            val  = '0;
            if (kind <= 2)
            begin
                alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1, 0) == 1);
                imem[n] = {alt ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
                val = alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]);
            end
            else if (kind <= 4)
            begin
                if (f3 == 3'd1)
                    imm = {7'h00, imm[4:0]};
                else if (f3 == 3'd5)
                begin
                    alt = imm[10];
                    imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                end
                imem[n] = {imm, 5'(rs1), f3, 5'(rd), OP_IMM};
                val = alu_ref(f3, alt, model_regs[rs1], sext12(imm));
            end
            else if (kind == 5)
            begin
                imem[n] = {uimm, 5'(rd), OP_LUI};
                val = {uimm, 12'b0};
            end
            else if (kind == 6)
            begin
                imem[n] = {12'(k * 4), 5'd0, 3'b010, 5'(rd), OP_LOAD};
                exp_ld_addr.push_back(32'(k * 4));
                val = model_mem[k];
            end
            else
            begin
                imm = 12'(k * 4);
                imem[n] = {imm[11:5], 5'(rs2), 5'd0, 3'b010, imm[4:0], OP_STORE};
                exp_st_addr.push_back(32'(k * 4));
                exp_st_data.push_back(model_regs[rs2]);
                model_mem[k] = model_regs[rs2];
            end
            if ((kind != 7) && (rd != 0))
                model_regs[rd] = val;
        end
        // Epilogue dumps x1 to x7 and then issues ECALL
        for (int r = 1; r < 8; r++)
        begin
            imm = 12'(EPI_BASE + 4 * (r - 1));
            imem[N_RANDOM + r - 1] = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], OP_STORE};
            exp_st_addr.push_back(32'(EPI_BASE + 4 * (r - 1)));
            exp_st_data.push_back(model_regs[r]);
        end
        imem[N_RANDOM + 7] = 32'h0000_0073;
    endtask

    // Sampled mid-cycle so the DUT sees the same levels at the next rising edge
    task automatic observe_port();
        check_value("o_instr_mem_rd", {31'b0, o_instr_mem_rd}, 32'd1);
        if (o_data_mem_en && (ecall_count > 0))
            report_error("data access started after ECALL retired");
        if (o_data_mem_en && i_dcache_done)
        begin
            pending = 1'b0;
            if (o_data_mem_rd_wr)
            begin
                if (exp_st_addr.size() == 0)
                    report_error("store completed with none expected");
                else
                begin
                    check_value("o_data_mem_addr", o_data_mem_addr, exp_st_addr.pop_front());
                    check_value("o_data_mem_in", o_data_mem_in, exp_st_data.pop_front());
                end
                dmem[o_data_mem_addr[8:2]] = o_data_mem_in;
            end
            else if (exp_ld_addr.size() == 0)
                report_error("load completed with none expected");
            else
                check_value("o_data_mem_addr", o_data_mem_addr, exp_ld_addr.pop_front());
        end
        if (o_ecall)
        begin
            ecall_count++;
            if (exp_st_addr.size() != 0)
                report_error("ECALL retired before all expected stores completed");
        end
    endtask

    task automatic drive_port();
        if (!o_data_mem_en)
        begin
            pending       = 1'b0;
            i_dcache_done = 1'b0;
        end
        else
        begin
            if (!pending)
            begin
                pending  = 1'b1;
                wait_cnt = $urandom_range(3, 0);
            end
            if (wait_cnt == 0)
            begin
                i_dcache_done  = 1'b1;
                i_data_mem_out = dmem[o_data_mem_addr[8:2]];
            end
            else
            begin
                i_dcache_done = 1'b0;
                wait_cnt--;
            end
        end
    endtask

    // Data memory responder
    initial
    begin
        pending  = 1'b0;
        wait_cnt = 0;
        @(negedge i_rst);
        forever
        begin
            @(negedge i_clk);
            observe_port();
            @(posedge i_clk);
            #2;
            drive_port();
        end
    end

    initial
    begin
        int cycles;
        errors         = 0;
        checks         = 0;
        ecall_count    = 0;
        i_rst          = 1'b1;
        i_dcache_done  = 1'b0;
        i_data_mem_out = '0;
        void'($urandom(SEED));
        gen_program();
        repeat (5) @(posedge i_clk);
        #2 i_rst = 1'b0;

        cycles = 0;
        while ((ecall_count == 0) && (cycles < TIMEOUT))
        begin
            @(posedge i_clk);
            cycles++;
        end
        if (ecall_count == 0)
            report_error("timeout, ECALL did not retire within 2000 cycles");

        // Catch a second pulse or a late access
        cycles = 0;
        while (cycles < 20)
        begin
            @(posedge i_clk);
            cycles++;
        end
        check_value("o_ecall pulse count", 32'(ecall_count), 32'd1);
        if (exp_st_addr.size() != 0)
            report_error($sformatf("%0d expected stores never completed", exp_st_addr.size()));
        if (exp_ld_addr.size() != 0)
            report_error($sformatf("%0d expected loads never completed", exp_ld_addr.size()));

        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut_i.u_assert.fail_count);
        if ((errors == 0) && (dut_i.u_assert.fail_count == 0))
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rv_pkg.sv
design/hazard_if.sv
design/fetch_unit.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/rv_core.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv
